/* bench/cp_bond_tb.sv */
// Testbench for the TX bonding control plane
// Clock, random stimulus, reference model, compare process and timeout

`timescale 1ns/1ps

module cp_bond_tb;

   localparam int CNTWIDTH    = 6;   // Count narrower than the 8-bit readback
   localparam int TEST_LEN    = 24 + 4 * 32 + 16 * 32 + 2 * 27 + 310 + 10;
   localparam int TIMEOUT_CYC = 2 * TEST_LEN;

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   cfg_wr;
   cp_bond_pkg::cfg_addr_e cfg_addr;
   logic [7:0]             cfg_wdata;
   logic [7:0]             cfg_rdata;
   cp_bond_pkg::strobe_t   master_in, us_in, ds_in;
   logic                   data_valid_raw, wr_flush, rd_flush;
   cp_bond_pkg::strobe_t   us_out, ds_out, comp_en;
   logic                   compin_wren, compin_rden;
   logic [19:0]            testbus;
   string                  test_name = "reset";
   int                     cycles = 0;

   // Model state with strobe bits in strobe_t order (dv, wren, rden)
   logic [6:0]          m_ctrl;
   logic [CNTWIDTH-1:0] m_cnt;
   logic [2:0]          m_us_out, m_ds_out, m_us_tap, m_ds_tap, m_busy, m_match;
   logic [CNTWIDTH-1:0] m_left [3];   // Remaining count per strobe

   cp_bond_top #(.CNTWIDTH (CNTWIDTH)) u_cp_bond_top (.*);

   always #2 clk = ~clk;   // 4 ns period

   // --------------------
   // Reference model
   // --------------------
   function automatic logic [2:0] source_level(logic [2:0] mst);
      case (m_ctrl[3:2])
         cp_bond_pkg::COMP_MASTER: return mst;
         cp_bond_pkg::COMP_US_TAP: return m_us_tap;
         cp_bond_pkg::COMP_DS_TAP: return m_ds_tap;
         default:                  return 3'b000;
      endcase
   endfunction

   function automatic void model_step();
      logic [2:0]          mst;
      logic [2:0]          usg;
      logic [2:0]          dsg;
      logic [2:0]          src;
      logic [2:0]          en;
      logic [2:0]          clr;
      logic [CNTWIDTH-1:0] n;
      logic [1:0]          s;
      mst = master_in;
      usg = m_ctrl[5] ? {3{m_ctrl[6]}} : us_in;   // Scan gating
      dsg = m_ctrl[5] ? {3{m_ctrl[6]}} : ds_in;
      src = source_level(mst);                    // Taps before this edge
      en  = {2'b11, data_valid_raw};
      clr = rst ? 3'b111 : {1'b0, wr_flush, rd_flush};
      for (int i = 0; i < 3; i++) begin
         s = 2'(i);
         n = (s == 2'd1 && m_ctrl[4]) ? m_cnt << 1 : m_cnt;   // Doubled wren count
         if (clr[s]) begin
            m_us_out[s] = 1'b0;
            m_ds_out[s] = 1'b0;
            m_us_tap[s] = 1'b0;
            m_ds_tap[s] = 1'b0;
            m_busy[s]   = 1'b0;
            m_left[s]   = '0;
            m_match[s]  = 1'b0;
         end else if (en[s]) begin
            m_us_out[s] = m_ctrl[0] ? mst[s] : dsg[s];
            m_ds_out[s] = m_ctrl[1] ? mst[s] : usg[s];
            m_us_tap[s] = usg[s];
            m_ds_tap[s] = dsg[s];
            m_match[s]  = m_busy[s] && m_left[s] == '0;
            if (!m_busy[s]) begin
               m_busy[s] = src[s];
               m_left[s] = src[s] ? n : m_left[s];
            end else if (m_left[s] != '0) begin
               m_left[s] = m_left[s] - CNTWIDTH'(1);
            end else begin
               m_busy[s] = 1'b0;
            end
         end
      end
      if (rst) begin
         m_ctrl = '0;
         m_cnt  = '0;
      end else if (cfg_wr && cfg_addr == cp_bond_pkg::ADDR_CTRL) begin
         m_ctrl = cfg_wdata[6:0];
      end else if (cfg_wr) begin
         m_cnt = CNTWIDTH'(cfg_wdata);   // Low CNTWIDTH bits of the write
      end
   endfunction

   task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("error: test %s, %s expected %0h actual %0h", test_name, what, exp, act);
         $display("Checks failed");
         $fatal(1, "first mismatch stops the run");
      end
   endtask

   // --------------------
   // Compare and timeout
   // --------------------
   always @(posedge clk) begin
      logic [7:0]  exp_rd;
      logic [2:0]  lvl;
      logic [19:0] bus;
      #1;   // Sample after the registers settle
      model_step();
      exp_rd   = (cfg_addr == cp_bond_pkg::ADDR_CTRL) ? {1'b0, m_ctrl} : 8'(m_cnt);
      lvl      = source_level(master_in);
      bus      = {1'b0, data_valid_raw,
                  master_in.dv, us_in.dv, ds_in.dv, m_ds_tap[2], m_us_tap[2], m_match[2],
                  master_in.wren, us_in.wren, ds_in.wren, m_ds_tap[1], m_us_tap[1], m_match[1],
                  master_in.rden, us_in.rden, ds_in.rden, m_ds_tap[0], m_us_tap[0], m_match[0]};
      check_value("us_out", 32'(m_us_out), 32'(us_out));
      check_value("ds_out", 32'(m_ds_out), 32'(ds_out));
      check_value("comp_en", 32'(m_match), 32'(comp_en));
      check_value("compin_wren", 32'(lvl[1]), 32'(compin_wren));
      check_value("compin_rden", 32'(lvl[0]), 32'(compin_rden));
      check_value("testbus", 32'(bus), 32'(testbus));
      check_value("cfg_rdata", 32'(exp_rd), 32'(cfg_rdata));
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYC) begin
         $display("Checks failed");
         $fatal(1, "simulation ran past its cycle limit");
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   task automatic idle_inputs();
      cfg_wr         = 1'b0;
      cfg_addr       = cp_bond_pkg::ADDR_CTRL;
      cfg_wdata      = 8'h00;
      master_in      = 3'b000;
      us_in          = 3'b000;
      ds_in          = 3'b000;
      data_valid_raw = 1'b1;
      wr_flush       = 1'b0;
      rd_flush       = 1'b0;
   endtask

   task automatic write_reg(cp_bond_pkg::cfg_addr_e addr, logic [7:0] data);
      @(negedge clk);
      cfg_wr    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge clk);
      cfg_wr    = 1'b0;
   endtask

   task automatic pulse_strobes(int gap);
      @(negedge clk);
      master_in = 3'b111;
      us_in     = 3'b111;
      ds_in     = 3'b111;
      @(negedge clk);
      master_in = 3'b000;
      us_in     = 3'b000;
      ds_in     = 3'b000;
      repeat (gap) @(negedge clk);
   endtask

   task automatic drive_random(int n, logic stall);
      repeat (n) begin
         @(negedge clk);
         master_in = 3'($urandom);
         us_in     = 3'($urandom);
         ds_in     = 3'($urandom);
         if (stall) begin
            data_valid_raw = 1'($urandom);
            wr_flush       = ($urandom_range(0, 9) == 0);
            rd_flush       = ($urandom_range(0, 9) == 0);
            cfg_addr       = cp_bond_pkg::cfg_addr_e'(1'($urandom));
         end
      end
   endtask

   initial begin
      rst = 1'b1;
      idle_inputs();
      void'($urandom(14447));
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_name = "registers";
      write_reg(cp_bond_pkg::ADDR_CTRL, 8'hFF);
      write_reg(cp_bond_pkg::ADDR_COUNT, 8'hA5);
      @(negedge clk);
      cfg_addr = cp_bond_pkg::ADDR_CTRL;   // Bit 7 reads zero
      write_reg(cp_bond_pkg::ADDR_CTRL, 8'h00);

      test_name = "distribution";
      for (int m = 0; m < 4; m++) begin
         write_reg(cp_bond_pkg::ADDR_CTRL, 8'(m));
         drive_random(30, 1'b0);
      end
      idle_inputs();

      test_name = "compensation";
      for (int sel = 0; sel < 4; sel++) begin
         for (int k = 0; k < 4; k++) begin
            write_reg(cp_bond_pkg::ADDR_COUNT, 8'((1 << k) - 1));   // N = 0, 1, 3, 7
            write_reg(cp_bond_pkg::ADDR_CTRL, 8'(((k % 2) << 4) | (sel << 2)));
            pulse_strobes(1);
            pulse_strobes(2);   // Lands while counting for the longer counts
            repeat (2 * ((1 << k) - 1) + 8) @(negedge clk);
         end
      end

      test_name = "scan gating";
      for (int v = 0; v < 2; v++) begin
         write_reg(cp_bond_pkg::ADDR_CTRL, 8'(32'h20 | (v << 6) | v | (v << 2)));
         drive_random(25, 1'b0);
      end

      test_name = "back-pressure and flushes";
      write_reg(cp_bond_pkg::ADDR_COUNT, 8'd4);
      write_reg(cp_bond_pkg::ADDR_CTRL, 8'h11);   // us_master and double_read
      drive_random(200, 1'b1);
      write_reg(cp_bond_pkg::ADDR_CTRL, 8'h0A);   // ds_master and downstream tap source
      drive_random(100, 1'b1);
      @(negedge clk);
      idle_inputs();
      repeat (4) @(negedge clk);
      $display("All checks passed");
      $finish;
   end

endmodule

/* project.f */
verilog/cp_bond_pkg.sv
verilog/cp_cfg_regs.sv
verilog/cp_dist_pair.sv
verilog/cp_comp_cntr.sv
verilog/cp_bond.sv
verilog/cp_bond_top.sv
bench/cp_bond_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bonding control plane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f \
   --top-module cp_bond_tb -o cp_bond_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cp_bond_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit $status
fi
echo "Simulation finished"
exit 0

/* verilog/cp_bond.sv */
// Channel-bonding block for the dv, wren and rden strobes
// Scan gating, wren count doubling, distribution pairs, counters, test bus

`timescale 1ns/1ps

module cp_bond #(
   parameter int CNTWIDTH = 8
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     data_valid_raw,   // Read side back-pressure
   input  logic                     wr_flush,
   input  logic                     rd_flush,
   input  cp_bond_pkg::bond_cfg_t   cfg,
   input  logic [CNTWIDTH-1:0]      comp_cnt,
   input  cp_bond_pkg::strobe_t     master_in,
   input  cp_bond_pkg::strobe_t     us_in,
   input  cp_bond_pkg::strobe_t     ds_in,
   output cp_bond_pkg::strobe_t     us_out,
   output cp_bond_pkg::strobe_t     ds_out,
   output cp_bond_pkg::strobe_t     comp_en,
   output logic                     compin_wren,
   output logic                     compin_rden,
   output logic [19:0]              testbus
);

   cp_bond_pkg::strobe_t us_in_g;    // Neighbor inputs after scan gating
   cp_bond_pkg::strobe_t ds_in_g;
   cp_bond_pkg::strobe_t us_tap;
   cp_bond_pkg::strobe_t ds_tap;
   cp_bond_pkg::strobe_t us_out_w;
   cp_bond_pkg::strobe_t ds_out_w;
   logic [CNTWIDTH-1:0]  cnt_wren;   // Possibly doubled count
   logic                 match_dv;
   logic                 match_wren;
   logic                 match_rden;

   // --------------------
   // Scan gating and count doubling
   // --------------------
   assign us_in_g  = cfg.dft_en ? {3{cfg.dft_value}} : us_in;
   assign ds_in_g  = cfg.dft_en ? {3{cfg.dft_value}} : ds_in;
   assign cnt_wren = cfg.double_read ? (comp_cnt << 1) : comp_cnt;   // Truncated

   // --------------------
   // Data valid path, free running
   // --------------------
   cp_dist_pair u_pair_dv (
      .clk (clk), .rst (rst), .clear (1'b0), .data_enable (1'b1),
      .master_in (master_in.dv), .us_in (us_in_g.dv), .ds_in (ds_in_g.dv),
      .us_master (cfg.us_master), .ds_master (cfg.ds_master),
      .us_out (us_out_w.dv), .ds_out (ds_out_w.dv),
      .us_tap (us_tap.dv), .ds_tap (ds_tap.dv)
   );

   cp_comp_cntr #(.CNTWIDTH (CNTWIDTH)) u_cntr_dv (
      .clk (clk), .rst (rst), .clear (1'b0), .data_enable (1'b1),
      .master_in (master_in.dv), .us_tap (us_tap.dv), .ds_tap (ds_tap.dv),
      .compin_sel (cfg.compin_sel), .comp_cnt (comp_cnt),
      .comp_match (match_dv), .compin_level ()   // No dv level output
   );

   // --------------------
   // Write enable path
   // --------------------
   cp_dist_pair u_pair_wren (
      .clk (clk), .rst (rst), .clear (wr_flush), .data_enable (1'b1),
      .master_in (master_in.wren), .us_in (us_in_g.wren), .ds_in (ds_in_g.wren),
      .us_master (cfg.us_master), .ds_master (cfg.ds_master),
      .us_out (us_out_w.wren), .ds_out (ds_out_w.wren),
      .us_tap (us_tap.wren), .ds_tap (ds_tap.wren)
   );

   cp_comp_cntr #(.CNTWIDTH (CNTWIDTH)) u_cntr_wren (
      .clk (clk), .rst (rst), .clear (wr_flush), .data_enable (1'b1),
      .master_in (master_in.wren), .us_tap (us_tap.wren), .ds_tap (ds_tap.wren),
      .compin_sel (cfg.compin_sel), .comp_cnt (cnt_wren),
      .comp_match (match_wren), .compin_level (compin_wren)
   );

   // --------------------
   // Read enable path, stalled by back-pressure
   // --------------------
   cp_dist_pair u_pair_rden (
      .clk (clk), .rst (rst), .clear (rd_flush), .data_enable (data_valid_raw),
      .master_in (master_in.rden), .us_in (us_in_g.rden), .ds_in (ds_in_g.rden),
      .us_master (cfg.us_master), .ds_master (cfg.ds_master),
      .us_out (us_out_w.rden), .ds_out (ds_out_w.rden),
      .us_tap (us_tap.rden), .ds_tap (ds_tap.rden)
   );

   cp_comp_cntr #(.CNTWIDTH (CNTWIDTH)) u_cntr_rden (
      .clk (clk), .rst (rst), .clear (rd_flush), .data_enable (data_valid_raw),
      .master_in (master_in.rden), .us_tap (us_tap.rden), .ds_tap (ds_tap.rden),
      .compin_sel (cfg.compin_sel), .comp_cnt (comp_cnt),
      .comp_match (match_rden), .compin_level (compin_rden)
   );

   assign us_out  = us_out_w;
   assign ds_out  = ds_out_w;
   assign comp_en = {match_dv, match_wren, match_rden};

   // Test bus shows the ungated neighbor inputs
   assign testbus = {1'b0, data_valid_raw,
                     master_in.dv, us_in.dv, ds_in.dv,
                     ds_tap.dv, us_tap.dv, match_dv,
                     master_in.wren, us_in.wren, ds_in.wren,
                     ds_tap.wren, us_tap.wren, match_wren,
                     master_in.rden, us_in.rden, ds_in.rden,
                     ds_tap.rden, us_tap.rden, match_rden};

endmodule

/* verilog/cp_bond_pkg.sv */
// Shared types for the TX channel-bonding control plane
// Compensation source, register addresses, config and strobe bundles

package cp_bond_pkg;

   // --------------------
   // Compensation source select
   // --------------------
   typedef enum logic [1:0] {
      COMP_MASTER = 2'd0,   // Own lane strobe
      COMP_US_TAP = 2'd1,   // Strobe arriving from upstream
      COMP_DS_TAP = 2'd2,   // Strobe arriving from downstream
      COMP_OFF    = 2'd3    // Counter disabled
   } compin_sel_e;

   // --------------------
   // Config register map
   // --------------------
   typedef enum logic {
      ADDR_CTRL  = 1'b0,    // Control register
      ADDR_COUNT = 1'b1     // Compensation count
   } cfg_addr_e;

   // Control register fields, listed from bit 0 upward in the register.
   // The register block maps each bit to its field by name.
   typedef struct packed {
      logic        us_master;    // Lane drives upstream direction
      logic        ds_master;    // Lane drives downstream direction
      compin_sel_e compin_sel;   // Counter source
      logic        double_read;  // Doubles the wren count
      logic        dft_en;       // Scan gating of neighbor inputs
      logic        dft_value;    // Forced neighbor value in scan
   } bond_cfg_t;

   // --------------------
   // Control strobe bundle
   // --------------------
   typedef struct packed {
      logic dv;     // Data valid
      logic wren;   // FIFO write enable
      logic rden;   // FIFO read enable
   } strobe_t;

endpackage

/* verilog/cp_bond_top.sv */
// Top level of the TX bonding control plane
// Configuration registers joined to the bonding block

`timescale 1ns/1ps

module cp_bond_top #(
   parameter int CNTWIDTH = 8
) (
   input  logic                     clk,
   input  logic                     rst,
   // Configuration port
   input  logic                     cfg_wr,
   input  cp_bond_pkg::cfg_addr_e   cfg_addr,
   input  logic [7:0]               cfg_wdata,
   output logic [7:0]               cfg_rdata,
   // Bonding inputs
   input  cp_bond_pkg::strobe_t     master_in,
   input  cp_bond_pkg::strobe_t     us_in,
   input  cp_bond_pkg::strobe_t     ds_in,
   input  logic                     data_valid_raw,
   input  logic                     wr_flush,
   input  logic                     rd_flush,
   // Bonding outputs
   output cp_bond_pkg::strobe_t     us_out,
   output cp_bond_pkg::strobe_t     ds_out,
   output cp_bond_pkg::strobe_t     comp_en,
   output logic                     compin_wren,
   output logic                     compin_rden,
   output logic [19:0]              testbus
);

   cp_bond_pkg::bond_cfg_t cfg;
   logic [CNTWIDTH-1:0]    comp_cnt;

   // --------------------
   // Register block
   // --------------------
   cp_cfg_regs #(.CNTWIDTH (CNTWIDTH)) u_cfg_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_wr    (cfg_wr),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg),
      .comp_cnt  (comp_cnt)
   );

   // --------------------
   // Bonding logic
   // --------------------
   cp_bond #(.CNTWIDTH (CNTWIDTH)) u_bond (
      .clk            (clk),
      .rst            (rst),
      .data_valid_raw (data_valid_raw),
      .wr_flush       (wr_flush),
      .rd_flush       (rd_flush),
      .cfg            (cfg),
      .comp_cnt       (comp_cnt),
      .master_in      (master_in),
      .us_in          (us_in),
      .ds_in          (ds_in),
      .us_out         (us_out),
      .ds_out         (ds_out),
      .comp_en        (comp_en),
      .compin_wren    (compin_wren),
      .compin_rden    (compin_rden),
      .testbus        (testbus)
   );

endmodule

/* verilog/cp_cfg_regs.sv */
// Bonding configuration registers
// Control and compensation count registers with combinational readback

`timescale 1ns/1ps

module cp_cfg_regs #(
   parameter int CNTWIDTH = 8
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_wr,      // Write strobe
   input  cp_bond_pkg::cfg_addr_e   cfg_addr,
   input  logic [7:0]               cfg_wdata,
   output logic [7:0]               cfg_rdata,   // Readback for cfg_addr
   output cp_bond_pkg::bond_cfg_t   cfg,
   output logic [CNTWIDTH-1:0]      comp_cnt
);

   cp_bond_pkg::bond_cfg_t ctrl_q;
   logic [CNTWIDTH-1:0]    cnt_q;
   logic [15:0]            wdata_ext;   // Zero extended write data
   logic [15:0]            cnt_ext;     // Zero extended count for readback

   assign wdata_ext = {8'h00, cfg_wdata};
   assign cnt_ext   = 16'(cnt_q);

   // --------------------
   // Register writes
   // --------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_q <= '0;
         cnt_q  <= '0;
      end else if (cfg_wr) begin
         case (cfg_addr)
            cp_bond_pkg::ADDR_CTRL: begin
               ctrl_q.us_master   <= cfg_wdata[0];
               ctrl_q.ds_master   <= cfg_wdata[1];
               ctrl_q.compin_sel  <= cp_bond_pkg::compin_sel_e'(cfg_wdata[3:2]);
               ctrl_q.double_read <= cfg_wdata[4];
               ctrl_q.dft_en      <= cfg_wdata[5];
               ctrl_q.dft_value   <= cfg_wdata[6];
            end
            cp_bond_pkg::ADDR_COUNT: begin
               cnt_q <= wdata_ext[CNTWIDTH-1:0];   // Low CNTWIDTH bits
            end
            default: ;
         endcase
      end
   end

   // --------------------
   // Readback
   // --------------------
   always_comb begin
      cfg_rdata = '0;
      case (cfg_addr)
         cp_bond_pkg::ADDR_CTRL: begin
            cfg_rdata = {1'b0,
                         ctrl_q.dft_value,
                         ctrl_q.dft_en,
                         ctrl_q.double_read,
                         ctrl_q.compin_sel,
                         ctrl_q.ds_master,
                         ctrl_q.us_master};
         end
         cp_bond_pkg::ADDR_COUNT: cfg_rdata = cnt_ext[7:0];
         default: ;
      endcase
   end

   assign cfg      = ctrl_q;
   assign comp_cnt = cnt_q;

endmodule

/* verilog/cp_comp_cntr.sv */
// Compensation counter for one strobe
// Fires a one-cycle aligned enable N+1 enabled cycles after a source event

`timescale 1ns/1ps

module cp_comp_cntr #(
   parameter int CNTWIDTH = 8
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       clear,         // Flush of this strobe path
   input  logic                       data_enable,   // Low freezes the counter
   input  logic                       master_in,
   input  logic                       us_tap,
   input  logic                       ds_tap,
   input  cp_bond_pkg::compin_sel_e   compin_sel,
   input  logic [CNTWIDTH-1:0]        comp_cnt,      // Delay N
   output logic                       comp_match,    // Aligned enable
   output logic                       compin_level   // Selected source level
);

   typedef enum logic {
      ST_IDLE,
      ST_COUNT
   } state_e;

   state_e              state_q;
   logic [CNTWIDTH-1:0] cnt_q;
   logic                src;

   // --------------------
   // Source select
   // --------------------
   always_comb begin
      case (compin_sel)
         cp_bond_pkg::COMP_MASTER: src = master_in;
         cp_bond_pkg::COMP_US_TAP: src = us_tap;
         cp_bond_pkg::COMP_DS_TAP: src = ds_tap;
         default:                  src = 1'b0;   // COMP_OFF
      endcase
   end

   assign compin_level = src;

   // --------------------
   // Counter FSM
   // --------------------
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         state_q    <= ST_IDLE;
         cnt_q      <= '0;
         comp_match <= 1'b0;
      end else if (data_enable) begin
         comp_match <= 1'b0;   // Pulse lasts one enabled cycle
         case (state_q)
            ST_IDLE: begin
               if (src) begin
                  cnt_q   <= comp_cnt;
                  state_q <= ST_COUNT;
               end
            end
            ST_COUNT: begin
               // New source events are ignored until the pulse has fired
               if (cnt_q != '0) begin
                  cnt_q <= cnt_q - CNTWIDTH'(1);
               end else begin
                  comp_match <= 1'b1;
                  state_q    <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

/* verilog/cp_dist_pair.sv */
// Registered upstream/downstream distribution of one control strobe
// Also registers the arriving neighbor strobes as taps

`timescale 1ns/1ps

module cp_dist_pair (
   input  logic clk,
   input  logic rst,
   input  logic clear,         // Flush of this strobe path
   input  logic data_enable,   // Low holds all registers
   input  logic master_in,     // Own lane strobe
   input  logic us_in,         // From upstream neighbor
   input  logic ds_in,         // From downstream neighbor
   input  logic us_master,
   input  logic ds_master,
   output logic us_out,        // Toward upstream neighbor
   output logic ds_out,        // Toward downstream neighbor
   output logic us_tap,
   output logic ds_tap
);

   logic us_next;
   logic ds_next;

   // A non-master lane passes the strobe through in the same direction
   // it was travelling, so the upstream output relays the downstream input
   assign us_next = us_master ? master_in : ds_in;
   assign ds_next = ds_master ? master_in : us_in;

   // --------------------
   // Forwarding registers
   // --------------------
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         us_out <= 1'b0;
         ds_out <= 1'b0;
      end else if (data_enable) begin
         us_out <= us_next;
         ds_out <= ds_next;
      end
   end

   // --------------------
   // Neighbor taps
   // --------------------
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         us_tap <= 1'b0;
         ds_tap <= 1'b0;
      end else if (data_enable) begin
         us_tap <= us_in;   // Feeds the compensation counter
         ds_tap <= ds_in;
      end
   end

endmodule
